//--- verilog.f
+incdir+design
design/schedPkg.sv
design/bankGroupQueue.sv
design/groupArbiter.sv
design/burstIssue.sv
design/bankGroupScheduler.sv
test/sched_checker.sv
test/schedTb.sv

//--- Makefile
TOP = schedTb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- test/schedTb.sv
`timescale 1ns/1ns

`include "sched_settings.svh"

module schedTb import schedPkg::*; ();

    localparam int requestBudget = 320;                      // Tests 2, 4 and 5
    localparam int cycleLimit    = 8 * requestBudget + 200;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       reqValid;
    groupT      reqGroup;
    bankT       reqBank;
    colT        reqCol;
    logic [3:0] creditReturn;
    logic       cmdValid;
    groupT      cmdGroup;
    bankT       cmdBank;
    colT        cmdCol;
    logic       cmdCredit;

    logic [31:0] lfsr = 32'hd531_df10;
    int   credits [4];          // Host credits per group
    bankT modelBank [4][$];     // Requests not yet seen as commands
    colT  modelCol [4][$];
    int   served [4];           // Commands per group within one rotation
    int   watched = 0;          // Commands seen while burst runs are judged
    int   outstanding = 0;      // Commands the PHY has not credited back
    int   holdLeft = 0;         // Cycles left in a PHY stall
    bit   holdEnable = 1'b0;
    bit   forceHold = 1'b0;
    bit   burstWatch = 1'b0;
    int   runGroup = -1;
    int   runLen = 0;
    bit   othersBusy = 1'b0;    // Another group waited during the whole run
    int   satHits = 0;
    int   sent = 0;
    int   cycles = 0;
    int   checks = 0;
    int   errors = 0;
    int   testErrors = 0;

    bankGroupScheduler uut (.*);

    always #20 clk = ~clk;

    always @(negedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles, traffic did not finish", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    // Fibonacci LFSR on taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic tally(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic checkGroup(input string name, input groupT exp, input groupT act);
        tally(name, 32'(exp), 32'(act));
    endtask

    task automatic checkBank(input string name, input bankT exp, input bankT act);
        tally(name, 32'(exp), 32'(act));
    endtask

    task automatic checkCol(input string name, input colT exp, input colT act);
        tally(name, 32'(exp), 32'(act));
    endtask

    task automatic checkCount(input string name, input logic [31:0] exp, input logic [31:0] act);
        tally(name, exp, act);
    endtask

    task automatic reportError(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    task automatic finishTest(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - testErrors);
        testErrors = errors;
    endtask

    // Burst runs are judged only while other groups have work queued
    task automatic trackRun(input groupT g);
        bit others;
        others = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i != int'(g) && modelBank[i].size() != 0) others = 1'b1;
        end
        if (int'(g) != runGroup) begin
            runGroup   = int'(g);
            runLen     = 0;
            othersBusy = 1'b1;
        end
        runLen++;
        watched++;
        if (watched <= 4 * `SCHED_MAX_BURSTS) served[g]++;   // Four runs at most
        othersBusy = othersBusy && others;
        if (runLen > `SCHED_MAX_BURSTS && othersBusy) begin
            reportError($sformatf("group %0d sent %0d commands in a row", g, runLen));
        end
    endtask

    task automatic sampleOutputs();
        groupT g;
        checkCount("cmdValid", 32'(creditReturn != 4'b0000), 32'(cmdValid));
        for (int i = 0; i < 4; i++) begin
            if (creditReturn[i]) begin
                credits[i]++;   // Slot back to the host
                g = groupT'(i);
            end
        end
        if (creditReturn != 4'b0000) begin
            checkCount("creditReturn bits", 1, $countones(creditReturn));
            checkGroup("cmdGroup", g, cmdGroup);
        end
        if (cmdValid !== 1'b1) return;
        g = cmdGroup;
        outstanding++;
        if (outstanding > `SCHED_PHY_CREDITS) reportError("PHY got more commands than credits");
        if (outstanding == `SCHED_PHY_CREDITS) satHits++;
        if (burstWatch) trackRun(g);
        if (modelBank[g].size() == 0) begin
            reportError($sformatf("command for group %0d with no request pending", g));
            return;
        end
        checkBank("cmdBank", modelBank[g].pop_front(), cmdBank);
        checkCol("cmdCol", modelCol[g].pop_front(), cmdCol);
    endtask

    // PHY consumes at random with optional long stalls
    task automatic stepPhy();
        cmdCredit = 1'b0;
        if (holdLeft > 0) begin
            holdLeft--;
        end else if (holdEnable && randBits(4) == 0) begin
            holdLeft = 8 + int'(randBits(4));
        end
        if (forceHold || holdLeft > 0 || outstanding == 0) return;
        if (randBits(1) == 1) begin
            cmdCredit = 1'b1;
            outstanding--;
        end
    endtask

    task automatic tick();
        @(negedge clk);
        sampleOutputs();
        stepPhy();
        reqValid = 1'b0;   // Idle unless a request follows
    endtask

    task automatic pushRequest(input groupT g);
        reqValid = 1'b1;
        reqGroup = g;
        reqBank  = bankT'(randBits(2));
        reqCol   = colT'(randBits(8));
        modelBank[g].push_back(reqBank);
        modelCol[g].push_back(reqCol);
        credits[g]--;
        sent++;
    endtask

    task automatic randomTraffic(input int count);
        groupT g;
        sent = 0;
        while (sent < count) begin
            tick();
            g = groupT'(randBits(2));
            if (randBits(2) != 0 && credits[g] > 0) pushRequest(g);   // Else idle
        end
    endtask

    task automatic drainAll();
        while (modelBank[0].size() + modelBank[1].size() + modelBank[2].size()
               + modelBank[3].size() != 0 || outstanding != 0) tick();
        tick();
        for (int i = 0; i < 4; i++) begin
            checkCount($sformatf("credits[%0d]", i), `SCHED_QUEUE_DEPTH, credits[i]);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        reqValid  = 1'b0;
        reqGroup  = '0;
        reqBank   = '0;
        reqCol    = '0;
        cmdCredit = 1'b0;
        for (int i = 0; i < 4; i++) credits[i] = `SCHED_QUEUE_DEPTH;

        repeat (5) begin
            @(negedge clk);
            checkCount("cmdValid", 0, 32'(cmdValid));
            checkCount("creditReturn", 0, 32'(creditReturn));
        end
        rst_n = 1'b1;
        tick();
        checkCount("cmdValid", 0, 32'(cmdValid));
        checkCount("creditReturn", 0, 32'(creditReturn));
        finishTest(1, "reset state");

        randomTraffic(200);
        finishTest(2, "per-group order");
        drainAll();
        finishTest(3, "host credits");

        holdEnable = 1'b1;
        satHits    = 0;
        randomTraffic(100);
        holdEnable = 1'b0;
        drainAll();
        if (satHits == 0) reportError("PHY credits never ran out");
        finishTest(4, "PHY back-pressure");

        // Fill every queue behind a stalled PHY
        forceHold = 1'b1;
        for (int i = 0; credits[0] + credits[1] + credits[2] + credits[3] > 0; i++) begin
            tick();
            if (credits[i % 4] > 0) pushRequest(groupT'(i % 4));
        end
        forceHold  = 1'b0;
        burstWatch = 1'b1;
        drainAll();
        burstWatch = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (served[i] == 0) reportError($sformatf("group %0d not served within one rotation", i));
        end
        finishTest(5, "burst budget");

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- test/sched_checker.sv
`timescale 1ns/1ns

`include "sched_settings.svh"

module sched_checker import schedPkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] groupReq,
    input logic       canIssue,
    input logic       grantValid,
    input groupT      grantGroup,
    input logic       cmdValid,
    input logic [3:0] creditReturn,
    input phyCreditT  phyCredits    // Issue stage counter
);

    // Pop only from a queue with data, and only with a free PHY slot
    grantNeedsWork: assert property (@(posedge clk) disable iff (!rst_n)
        grantValid |-> (groupReq[grantGroup] && canIssue))
        else $error("grant on group %0d without request or PHY credit", grantGroup);

    creditOneHot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(creditReturn))
        else $error("creditReturn %b has more than one bit set", creditReturn);

    // Host credit goes back with the command
    creditWithCmd: assert property (@(posedge clk) disable iff (!rst_n)
        (creditReturn != 4'b0000) |-> cmdValid)
        else $error("creditReturn pulse without cmdValid");

    phyCreditCap: assert property (@(posedge clk) disable iff (!rst_n)
        phyCredits <= phyCreditT'(`SCHED_PHY_CREDITS))
        else $error("PHY credit count %0d above its start value", phyCredits);

endmodule

bind bankGroupScheduler sched_checker ruleCheck (
    .clk          (clk),
    .rst_n        (rst_n),
    .groupReq     (groupReq),
    .canIssue     (canIssue),
    .grantValid   (grantValid),
    .grantGroup   (grantGroup),
    .cmdValid     (cmdValid),
    .creditReturn (creditReturn),
    .phyCredits   (issue.phyCredits)
);

//--- design/bankGroupScheduler.sv
`timescale 1ns/1ns

module bankGroupScheduler import schedPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reqValid,      // Host holds a credit for reqGroup
    input  groupT      reqGroup,
    input  bankT       reqBank,
    input  colT        reqCol,
    output logic [3:0] creditReturn,  // Host credit pulses
    output logic       cmdValid,      // Column command to the PHY
    output groupT      cmdGroup,
    output bankT       cmdBank,
    output colT        cmdCol,
    input  logic       cmdCredit
);

    logic [3:0] push;        // Write enable per queue
    logic [3:0] pop;         // Read enable per queue
    logic [3:0] groupReq;
    bankT       qHeadBank [4];
    colT        qHeadCol  [4];
    bankT       headBank;    // Head of the granted queue
    colT        headCol;
    logic       grantValid;
    groupT      grantGroup;
    logic       canIssue;
    logic       burstDone;

    for (genvar g = 0; g < 4; g++) begin : queueGen
        assign push[g] = reqValid && (reqGroup == groupT'(g));
        assign pop[g]  = grantValid && (grantGroup == groupT'(g));

        bankGroupQueue queue (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (push[g]),
            .pushBank (reqBank),
            .pushCol  (reqCol),
            .pop      (pop[g]),
            .notEmpty (groupReq[g]),
            .headBank (qHeadBank[g]),
            .headCol  (qHeadCol[g])
        );
    end

    // Head mux, steered by the arbiter
    assign headBank = qHeadBank[grantGroup];
    assign headCol  = qHeadCol[grantGroup];

    groupArbiter arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .groupReq   (groupReq),
        .canIssue   (canIssue),
        .burstDone  (burstDone),
        .grantValid (grantValid),
        .grantGroup (grantGroup)
    );

    burstIssue issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .grantValid   (grantValid),
        .grantGroup   (grantGroup),
        .headBank     (headBank),
        .headCol      (headCol),
        .cmdCredit    (cmdCredit),
        .canIssue     (canIssue),
        .burstDone    (burstDone),
        .cmdValid     (cmdValid),
        .cmdGroup     (cmdGroup),
        .cmdBank      (cmdBank),
        .cmdCol       (cmdCol),
        .creditReturn (creditReturn)
    );

endmodule

//--- design/burstIssue.sv
`timescale 1ns/1ns

`include "sched_settings.svh"

module burstIssue import schedPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       grantValid,   // Pop happens this cycle
    input  groupT      grantGroup,
    input  bankT       headBank,     // Head of the granted queue
    input  colT        headCol,
    input  logic       cmdCredit,    // PHY consumed one command
    output logic       canIssue,
    output logic       burstDone,
    output logic       cmdValid,
    output groupT      cmdGroup,
    output bankT       cmdBank,
    output colT        cmdCol,
    output logic [3:0] creditReturn  // One pulse per pop, per group
);

    phyCreditT phyCredits;   // Free slots at the PHY
    burstCntT  burstCnt;     // Pops so far in this run
    burstCntT  runCnt;       // Count seen by the current pop
    groupT     lastGroup;    // Group of the previous pop

    // A new group starts its run from zero
    assign runCnt = (grantGroup == lastGroup) ? burstCnt : '0;

    assign burstDone = grantValid && (runCnt == burstCntT'(`SCHED_MAX_BURSTS - 1));
    assign canIssue  = (phyCredits != '0);

    // Send and return may land together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phyCredits <= phyCreditT'(`SCHED_PHY_CREDITS);
        end else begin
            phyCredits <= phyCredits + phyCreditT'(cmdCredit) - phyCreditT'(grantValid);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burstCnt  <= '0;
            lastGroup <= '0;
        end else if (grantValid) begin
            burstCnt  <= burstDone ? '0 : runCnt + 1'b1;  // Budget spent, restart
            lastGroup <= grantGroup;
        end else if (canIssue) begin
            burstCnt  <= '0;   // Idle with credit, run is over
        end
        // Stall on PHY credit keeps the run count
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmdValid     <= 1'b0;
            creditReturn <= 4'b0000;
        end else begin
            cmdValid     <= grantValid;
            creditReturn <= grantValid ? (4'b0001 << grantGroup) : 4'b0000;
        end
    end

    // Command payload, qualified by cmdValid
    always_ff @(posedge clk) begin
        if (grantValid) begin
            cmdGroup <= grantGroup;
            cmdBank  <= headBank;
            cmdCol   <= headCol;
        end
    end

endmodule

//--- design/groupArbiter.sv
`timescale 1ns/1ns

module groupArbiter import schedPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] groupReq,   // Queue non-empty, bit 0 is group A
    input  logic       canIssue,   // Issue stage still holds PHY credit
    input  logic       burstDone,  // This pop used up the burst budget
    output logic       grantValid, // Mealy, pops the granted queue
    output groupT      grantGroup
);

    arbState_e state;
    arbState_e nextState;
    logic      inGroup;     // Any GROUP state

    // Group index to its FSM state
    function automatic arbState_e stateOf(input groupT idx);
        return arbState_e'({1'b0, idx} + 3'd1);
    endfunction

    // Next requesting group after 'from' in ring order
    // Falls back to 'from' itself when no other group requests
    function automatic arbState_e nextInRing(input logic [3:0] req, input groupT from);
        groupT     idx;
        arbState_e pick;
        pick = stateOf(from);
        // Walk backwards so the nearest requester wins
        for (int step = 3; step >= 1; step--) begin
            idx = from + groupT'(step);
            if (req[idx]) begin
                pick = stateOf(idx);
            end
        end
        return pick;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Selected group follows the state
    always_comb begin
        case (state)
            GROUP_A: grantGroup = 2'd0;
            GROUP_B: grantGroup = 2'd1;
            GROUP_C: grantGroup = 2'd2;
            GROUP_D: grantGroup = 2'd3;
            default: grantGroup = 2'd0;  // Idle, value unused
        endcase
    end

    assign inGroup = (state != IDLE);

    // Grant drops in the same cycle as canIssue
    assign grantValid = inGroup && groupReq[grantGroup] && canIssue;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                // Scan from D so that A is tried first, then B, C, D
                if (canIssue && (groupReq != 4'b0000)) begin
                    nextState = nextInRing(groupReq, 2'd3);
                end
            end
            default: begin
                if (groupReq[grantGroup] && !burstDone) begin
                    nextState = state;               // Hold the group
                end else if (canIssue) begin
                    nextState = nextInRing(groupReq, grantGroup);
                end else begin
                    nextState = IDLE;                // Back-pressure, park
                end
            end
        endcase
    end

endmodule

//--- design/bankGroupQueue.sv
`timescale 1ns/1ns

`include "sched_settings.svh"

module bankGroupQueue import schedPkg::*; #(
    parameter int DEPTH = `SCHED_QUEUE_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,      // Host request for this group
    input  bankT pushBank,
    input  colT  pushCol,
    input  logic pop,       // Arbiter grant on this group
    output logic notEmpty,
    output bankT headBank,  // Oldest entry, valid while notEmpty
    output colT  headCol
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bankT             bankMem [DEPTH];  // Payload only
    colT              colMem  [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;            // Occupancy

    // Wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] advance(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            bankMem[wrPtr] <= pushBank;
            colMem[wrPtr]  <= pushCol;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= advance(wrPtr);
            if (pop)  rdPtr <= advance(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither, level unchanged
            endcase
        end
    end

    assign notEmpty = (count != '0);
    assign headBank = bankMem[rdPtr];
    assign headCol  = colMem[rdPtr];

endmodule

//--- design/schedPkg.sv
package schedPkg;

    // Bank group index, four groups
    typedef logic [1:0] groupT;

    // Bank inside a group
    typedef logic [1:0] bankT;

    // Column address of a burst
    typedef logic [7:0] colT;

    // Downstream credit count, holds 0 to 2
    typedef logic [1:0] phyCreditT;

    // Pops in the current grant
    typedef logic [1:0] burstCntT;

    // Arbiter FSM, one state per bank group
    typedef enum logic [2:0] {
        IDLE,
        GROUP_A,
        GROUP_B,
        GROUP_C,
        GROUP_D
    } arbState_e;

endpackage

//--- design/sched_settings.svh
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// Entries per bank-group queue
// Also the host credits per group after reset
`define SCHED_QUEUE_DEPTH 4

// Pops allowed in one grant before the arbiter moves on
`define SCHED_MAX_BURSTS 3

// Commands the PHY can take before it returns a credit
`define SCHED_PHY_CREDITS 2

`endif
